// ==== sys_bus_top.f ====
+incdir+source
source/sys_bus_pkg.sv
source/sbus_if.sv
source/addr_decode.sv
source/bus_ctrl.sv
source/gpio_regs.sv
source/ram_port.sv
source/irq_ctrl.sv
source/sys_bus_top.sv
sim/sys_bus_assert.sv
sim/sys_bus_tb.sv

// ==== Makefile ====
TOP = sys_bus_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sys_bus_top.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== sim/sys_bus_tb.sv ====
`timescale 1ns/100ps
`include "sys_bus_config.svh"

module sys_bus_tb import sys_bus_pkg::*; ();

  localparam int N_RAM = 40;
  // Reset and hold take about 50 cycles and the transfers a few hundred
  localparam int MAX_CYCLES = 2000;
  localparam sb_adr_t SW_ADR = `SB_GPIO_BASE;
  localparam sb_adr_t LED_ADR = `SB_GPIO_BASE + 1;

  logic clk = 1'b0;
  logic rst_lck;
  logic m_cyc_i, m_stb_i, m_we_i, m_tga_i, inta_i, m_ack_o;
  sb_adr_t m_adr_i, ram_adr_o;
  sb_sel_t m_sel_i, ram_sel_o;
  sb_dat_t m_dat_i, m_dat_o, ram_dat_o, ram_dat_i;
  irq_vec_t irq_i;
  logic intr_o;
  logic [`SW_W-1:0] sw_i;
  logic [`LED_W-1:0] leds_o;
  logic ram_stb_o, ram_we_o, ram_ack_i;

  logic [31:0] lfsr = 32'h0341_029c;
  int err_cnt = 0;
  int xfer_cnt = 0;
  int ack_cnt = 0;
  int cycle_cnt = 0;
  sb_dat_t ram_mem [sb_adr_t];  // Words written so far
  logic ram_expect = 1'b0;  // Set for each memory request
  logic ram_busy = 1'b0;
  int ram_wait = 0;
  logic exp_we;
  sb_adr_t exp_adr;
  sb_sel_t exp_sel;
  sb_dat_t exp_dat;

  sys_bus_top sys_bus_top_inst (.*);

  always #50 clk = ~clk;

  always @(negedge clk) begin
    if (m_ack_o) ack_cnt++;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic next_rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'hA300_0000;  // Galois taps 32, 30, 26, 25
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_rand_bit()};
    end
    return v;
  endfunction

  // Pattern over the whole address for unwritten RAM words
  function automatic sb_dat_t fill_word(input sb_adr_t a);
    return a[15:0] ^ {a[18:16], a[18:16], 10'h0} ^ 16'h3C5A;
  endfunction

  function automatic sb_dat_t ram_word(input sb_adr_t a);
    if (ram_mem.exists(a)) return ram_mem[a];
    return fill_word(a);
  endfunction

  task automatic expect_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // One master cycle returning the read data and the cycles to ack
  task automatic bus_xfer(input logic io, input logic inta, input logic we, input sb_adr_t adr,
                          input sb_sel_t sel, input sb_dat_t dat, output sb_dat_t rdat,
                          output int lat);
    lat = 0;
    m_cyc_i = 1'b1;
    m_stb_i = 1'b1;
    m_tga_i = io;
    inta_i  = inta;
    m_we_i  = we;
    m_adr_i = adr;
    m_sel_i = sel;
    m_dat_i = dat;
    do begin
      @(posedge clk);
      #5;
      lat++;
    end while (!m_ack_o);
    rdat = m_dat_o;
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
    inta_i  = 1'b0;
    m_we_i  = 1'b0;
    xfer_cnt++;
    @(posedge clk);  // Sequencer back in idle
    #5;
  endtask

  // External RAM with 0 to 3 extra wait cycles
  initial begin : ram_model
    int wait_left;
    sb_dat_t word;
    ram_ack_i = 1'b0;
    ram_dat_i = '0;
    wait_left = 0;
    forever begin
      @(posedge clk);
      #5;
      if (ram_ack_i) begin
        ram_ack_i = 1'b0;
        ram_busy  = 1'b0;
      end else if (ram_stb_o) begin
        if (!ram_busy) begin
          assert (ram_expect) else begin
            err_cnt++;
            $display("RAM strobe at %0t ns without a memory request", $time);
          end
          ram_busy   = 1'b1;
          ram_expect = 1'b0;
          wait_left  = ram_wait;
          expect_equal("RAM address pins", ram_adr_o, exp_adr);
          expect_equal("RAM select pins", ram_sel_o, exp_sel);
          expect_equal("RAM write enable", ram_we_o, exp_we);
          if (exp_we) expect_equal("RAM data pins", ram_dat_o, exp_dat);
        end
        if (wait_left == 0) begin
          word = ram_word(ram_adr_o);
          if (ram_we_o) begin
            if (ram_sel_o[0]) word[7:0] = ram_dat_o[7:0];
            if (ram_sel_o[1]) word[15:8] = ram_dat_o[15:8];
            ram_mem[ram_adr_o] = word;
          end
          ram_dat_i = word;
          ram_ack_i = 1'b1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin : stimulus
    sb_dat_t rd;
    sb_dat_t wd;
    int lat;
    logic [`LED_W-1:0] led_exp;
    sb_adr_t adr;
    sb_adr_t ram_base;
    irq_vec_t pend;
    rst_lck = 1'b0;
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
    m_we_i  = 1'b0;
    m_tga_i = 1'b0;
    inta_i  = 1'b0;
    m_adr_i = '0;
    m_sel_i = '0;
    m_dat_i = '0;
    irq_i   = '0;
    sw_i    = `SW_W'(rand_bits(`SW_W));
    repeat (16) @(posedge clk);
    #5;
    rst_lck = 1'b1;
    irq_i   = '1;  // Edges during the hold must not set pending bits

    // Request waits out the reset hold
    bus_xfer(1'b1, 1'b0, 1'b0, SW_ADR, 2'b11, '0, rd, lat);
    expect_equal("ack delay after reset", lat, `RST_HOLD_CYCLES + 3);
    expect_equal("switch read", rd, sw_i);
    expect_equal("LEDs after reset", leds_o, 0);
    expect_equal("intr after reset hold", intr_o, 0);
    irq_i = '0;

    led_exp = '0;
    for (int s = 0; s < 4; s++) begin
      wd = sb_dat_t'(rand_bits(16));
      bus_xfer(1'b1, 1'b0, 1'b1, LED_ADR, sb_sel_t'(s), wd, rd, lat);
      if (s[0]) led_exp[7:0] = wd[7:0];
      if (s[1]) led_exp[`LED_W-1:8] = wd[`LED_W-1:8];
      expect_equal("GPIO write ack delay", lat, 3);
      expect_equal("LED pins", leds_o, led_exp);
      bus_xfer(1'b1, 1'b0, 1'b0, LED_ADR, 2'b11, '0, rd, lat);
      expect_equal("LED read", rd, {2'b00, led_exp});
      expect_equal("GPIO read ack delay", lat, 3);
    end
    bus_xfer(1'b1, 1'b0, 1'b1, SW_ADR, 2'b11, 16'hFFFF, rd, lat);  // Switches are read only
    expect_equal("LEDs after switch write", leds_o, led_exp);

    ram_base = sb_adr_t'(rand_bits(`SB_ADR_W));
    for (int i = 0; i < N_RAM; i++) begin
      exp_we   = next_rand_bit();
      exp_adr  = ram_base ^ sb_adr_t'(rand_bits(3));  // Eight words so that reads hit writes
      exp_sel  = sb_sel_t'(rand_bits(2));
      exp_dat  = sb_dat_t'(rand_bits(16));
      ram_wait = int'(rand_bits(2));
      wd = ram_word(exp_adr);
      ram_expect = 1'b1;
      bus_xfer(1'b0, 1'b0, exp_we, exp_adr, exp_sel, exp_dat, rd, lat);
      expect_equal("RAM request taken", ram_expect, 0);
      if (!exp_we) expect_equal("RAM read data", rd, wd);
    end

    adr = sb_adr_t'(rand_bits(`SB_ADR_W));
    if ((adr | sb_adr_t'(1)) == LED_ADR) adr = adr ^ sb_adr_t'(19'h100);
    bus_xfer(1'b1, 1'b0, 1'b0, adr, 2'b11, '0, rd, lat);
    expect_equal("unmapped read data", rd, `SB_DEF_DATA);
    expect_equal("unmapped read ack delay", lat, 2);
    bus_xfer(1'b1, 1'b0, 1'b1, adr, 2'b11, ~rd, rd, lat);
    expect_equal("unmapped write ack delay", lat, 2);
    expect_equal("LEDs after unmapped write", leds_o, led_exp);

    for (int r = 0; r < 2; r++) begin
      pend = irq_vec_t'(rand_bits(`IRQ_N));
      if (pend == '0) pend = 8'h81;
      irq_i = pend;
      @(posedge clk);
      #5;
      expect_equal("intr after request edges", intr_o, 1);
      for (int i = 0; i < `IRQ_N; i++) begin
        if (pend[i]) begin
          bus_xfer(1'b0, 1'b1, 1'b0, '0, 2'b11, '0, rd, lat);
          pend[i] = 1'b0;
          expect_equal("interrupt vector", rd, `SB_IRQ_VEC_BASE + i);
          expect_equal("INTA ack delay", lat, 2);
          expect_equal("intr after acknowledge", intr_o, pend != '0);
        end
      end
      irq_i = '0;
      @(posedge clk);
      #5;
    end

    repeat (2) @(posedge clk);
    #5;
    expect_equal("ack count", ack_cnt, xfer_cnt);
    $display("Summary: %0d check errors, %0d assertion failures", err_cnt,
             sys_bus_top_inst.sys_bus_assert_inst.fail_cnt);
    if (err_cnt == 0 && sys_bus_top_inst.sys_bus_assert_inst.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/sys_bus_assert.sv ====
`timescale 1ns/100ps
`include "sys_bus_config.svh"

module sys_bus_assert import sys_bus_pkg::*; (
  input logic              clk,
  input logic              rst_n_i,  // Internal reset after hold
  input logic              cyc_i,
  input logic              stb_i,
  input logic              inta_i,
  input slave_sel_e        slv_sel_i,
  input logic              ack_i,
  input logic              intr_i,
  input logic [`LED_W-1:0] leds_i,
  input logic              ram_stb_i,
  input logic              ram_ack_i,
  input sb_adr_t           ram_adr_i
);

  int   fail_cnt = 0;
  logic hold_q;  // Reset was held at the last edge

  always_ff @(posedge clk) begin
    hold_q <= !rst_n_i;
  end

  assert property (@(posedge clk) hold_q |-> !ack_i && !intr_i && !ram_stb_i && leds_i == '0)
    else begin
      fail_cnt++;
      $error("control output high during reset hold");
    end

  assert property (@(posedge clk) ack_i |=> !ack_i)
    else begin
      fail_cnt++;
      $error("m_ack_o longer than one cycle");
    end

  // Pins held until the RAM acks, then released
  assert property (@(posedge clk) ram_stb_i && !ram_ack_i |=> ram_stb_i && $stable(ram_adr_i))
    else begin
      fail_cnt++;
      $error("ram_stb_o or address not held until ram_ack_i");
    end

  assert property (@(posedge clk) ram_stb_i && ram_ack_i |=> !ram_stb_i)
    else begin
      fail_cnt++;
      $error("ram_stb_o not dropped after ram_ack_i");
    end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(cyc_i && stb_i) && !inta_i && slv_sel_i == SLV_GPIO
      |-> !ack_i ##1 !ack_i ##1 !ack_i ##1 ack_i)
    else begin
      fail_cnt++;
      $error("GPIO ack latency is not 3 cycles");
    end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(cyc_i && stb_i) && (inta_i || slv_sel_i == SLV_DEF) |-> !ack_i ##1 !ack_i ##1 ack_i)
    else begin
      fail_cnt++;
      $error("default or INTA ack latency is not 2 cycles");
    end

endmodule

bind sys_bus_top sys_bus_assert sys_bus_assert_inst (
  .clk       (clk),
  .rst_n_i   (rst_n),
  .cyc_i     (m_cyc_i),
  .stb_i     (m_stb_i),
  .inta_i    (inta_i),
  .slv_sel_i (slv_sel),
  .ack_i     (m_ack_o),
  .intr_i    (intr_o),
  .leds_i    (leds_o),
  .ram_stb_i (ram_stb_o),
  .ram_ack_i (ram_ack_i),
  .ram_adr_i (ram_adr_o)
);

// ==== source/sys_bus_top.sv ====
`timescale 1ns/100ps
`include "sys_bus_config.svh"

module sys_bus_top import sys_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_lck,

  // CPU master
  input  logic              m_cyc_i,
  input  logic              m_stb_i,
  input  logic              m_we_i,
  input  logic              m_tga_i,  // IO space
  input  sb_adr_t           m_adr_i,
  input  sb_sel_t           m_sel_i,
  input  sb_dat_t           m_dat_i,
  output sb_dat_t           m_dat_o,
  output logic              m_ack_o,
  input  logic              inta_i,

  // Interrupts
  input  irq_vec_t          irq_i,
  output logic              intr_o,

  // Switches and LEDs
  input  logic [`SW_W-1:0]  sw_i,
  output logic [`LED_W-1:0] leds_o,

  // External RAM
  output logic              ram_stb_o,
  output logic              ram_we_o,
  output sb_adr_t           ram_adr_o,
  output sb_sel_t           ram_sel_o,
  output sb_dat_t           ram_dat_o,
  input  sb_dat_t           ram_dat_i,
  input  logic              ram_ack_i
);

  sb_adr_t    dec_adr;
  logic       dec_io;
  slave_sel_e slv_sel;
  irq_id_t    iid;
  logic       irq_ack;
  logic       rst_n;

  sbus_if gpio_bus ();
  sbus_if ram_bus ();

  bus_ctrl bus_ctrl_inst (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .m_cyc_i   (m_cyc_i),
    .m_stb_i   (m_stb_i),
    .m_we_i    (m_we_i),
    .m_tga_i   (m_tga_i),
    .inta_i    (inta_i),
    .m_adr_i   (m_adr_i),
    .m_sel_i   (m_sel_i),
    .m_dat_i   (m_dat_i),
    .slv_sel_i (slv_sel),
    .iid_i     (iid),
    .irq_ack_o (irq_ack),
    .m_dat_o   (m_dat_o),
    .m_ack_o   (m_ack_o),
    .adr_o     (dec_adr),
    .io_o      (dec_io),
    .gpio_bus  (gpio_bus.master),
    .ram_bus   (ram_bus.master),
    .rst_n_o   (rst_n)
  );

  addr_decode addr_decode_inst (
    .io_i  (dec_io),
    .adr_i (dec_adr),
    .sel_o (slv_sel)
  );

  gpio_regs gpio_regs_inst (
    .clk    (clk),
    .bus    (gpio_bus.slave),
    .sw_i   (sw_i),
    .leds_o (leds_o)
  );

  ram_port ram_port_inst (
    .clk       (clk),
    .bus       (ram_bus.slave),
    .ram_stb_o (ram_stb_o),
    .ram_we_o  (ram_we_o),
    .ram_adr_o (ram_adr_o),
    .ram_sel_o (ram_sel_o),
    .ram_dat_o (ram_dat_o),
    .ram_dat_i (ram_dat_i),
    .ram_ack_i (ram_ack_i)
  );

  irq_ctrl irq_ctrl_inst (
    .clk     (clk),
    .rst_n_i (rst_n),
    .irq_i   (irq_i),
    .ack_i   (irq_ack),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

endmodule

// ==== source/irq_ctrl.sv ====
`timescale 1ns/100ps
`include "sys_bus_config.svh"

module irq_ctrl import sys_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  irq_vec_t irq_i,
  input  logic     ack_i,
  output logic     intr_o,
  output irq_id_t  iid_o
);

  irq_vec_t irq_q;
  irq_vec_t pend_q;
  irq_vec_t rise;
  irq_vec_t clr;

  assign rise = irq_i & ~irq_q;
  // Clears the request being acknowledged
  assign clr = ack_i ? (irq_vec_t'(1) << iid_o) : '0;

  always_ff @(posedge clk) begin
    irq_q <= irq_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~clr) | rise;  // New edge wins over a clear
    end
  end

  // Lowest pending index
  always_comb begin
    iid_o = '0;
    for (int i = `IRQ_N - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        iid_o = irq_id_t'(i);
      end
    end
  end

  assign intr_o = |pend_q;

endmodule

// ==== source/ram_port.sv ====
`timescale 1ns/100ps

module ram_port import sys_bus_pkg::*; (
  input  logic    clk,
  sbus_if.slave   bus,
  output logic    ram_stb_o,
  output logic    ram_we_o,
  output sb_adr_t ram_adr_o,
  output sb_sel_t ram_sel_o,
  output sb_dat_t ram_dat_o,
  input  sb_dat_t ram_dat_i,
  input  logic    ram_ack_i
);

  logic    ack_q;
  logic    start;
  logic    done;
  sb_dat_t rd_q;

  // New request, not while the pins are busy or the ack is out
  assign start = bus.stb && !ram_stb_o && !ack_q;
  assign done  = ram_stb_o && ram_ack_i;

  always_ff @(posedge clk) begin
    if (!bus.rst_n) begin
      ram_stb_o <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      ack_q <= done;
      if (done) begin
        ram_stb_o <= 1'b0;
      end else if (start) begin
        ram_stb_o <= 1'b1;
      end
    end
  end

  // Request held on the pins until the RAM acks
  always_ff @(posedge clk) begin
    if (start) begin
      ram_we_o  <= bus.we;
      ram_adr_o <= bus.adr;
      ram_sel_o <= bus.sel;
      ram_dat_o <= bus.dat_w;
    end
    if (done) begin
      rd_q <= ram_dat_i;
    end
  end

  assign bus.dat_r = rd_q;
  assign bus.ack   = ack_q;

endmodule

// ==== source/gpio_regs.sv ====
`timescale 1ns/100ps
`include "sys_bus_config.svh"

module gpio_regs import sys_bus_pkg::*; (
  input  logic             clk,
  sbus_if.slave            bus,
  input  logic [`SW_W-1:0] sw_i,
  output logic [`LED_W-1:0] leds_o
);

  logic [`LED_W-1:0] led_q;
  logic              ack_q;
  logic              access;
  sb_dat_t           rd_dat;

  // First cycle of a strobe only
  assign access = bus.stb && !ack_q;

  // Word 0 is the switches, word 1 the LEDs
  always_comb begin
    if (bus.adr[0]) begin
      rd_dat = sb_dat_t'(led_q);  // Unused high bits read zero
    end else begin
      rd_dat = sb_dat_t'(sw_i);
    end
  end

  always_ff @(posedge clk) begin
    if (!bus.rst_n) begin
      led_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && bus.we && bus.adr[0]) begin
        if (bus.sel[0]) led_q[7:0] <= bus.dat_w[7:0];
        if (bus.sel[1]) led_q[`LED_W-1:8] <= bus.dat_w[`LED_W-1:8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      bus.dat_r <= rd_dat;
    end
  end

  assign bus.ack = ack_q;
  assign leds_o  = led_q;

endmodule

// ==== source/bus_ctrl.sv ====
`timescale 1ns/100ps
`include "sys_bus_config.svh"

module bus_ctrl import sys_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst_lck,
  input  logic       m_cyc_i,
  input  logic       m_stb_i,
  input  logic       m_we_i,
  input  logic       m_tga_i,
  input  logic       inta_i,
  input  sb_adr_t    m_adr_i,
  input  sb_sel_t    m_sel_i,
  input  sb_dat_t    m_dat_i,
  input  slave_sel_e slv_sel_i,
  input  irq_id_t    iid_i,
  output logic       irq_ack_o,
  output sb_dat_t    m_dat_o,
  output logic       m_ack_o,
  output sb_adr_t    adr_o,
  output logic       io_o,
  sbus_if.master     gpio_bus,
  sbus_if.master     ram_bus,
  output logic       rst_n_o
);

  localparam int HOLD_W = $clog2(`RST_HOLD_CYCLES + 1);

  logic [HOLD_W-1:0] hold_cnt;
  logic              rst_n;
  bus_state_e        state;
  logic              stb_q;
  logic              inta_q;
  slave_sel_e        slv_q;
  logic              we_q;
  sb_adr_t           adr_q;
  sb_sel_t           sel_q;
  sb_dat_t           dat_q;
  sb_dat_t           slv_dat;
  sb_dat_t           reply;
  logic              slv_ack;
  logic              local_reply;

  // Reset hold, reloaded while rst_lck is low
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      hold_cnt <= HOLD_W'(`RST_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign rst_n   = (hold_cnt == '0);
  assign rst_n_o = rst_n;

  // Incoming request goes straight to the decoder
  assign adr_o = m_adr_i;
  assign io_o  = m_tga_i;

  // Both slave buses carry the latched request
  assign gpio_bus.stb   = stb_q && (slv_q == SLV_GPIO);
  assign gpio_bus.we    = we_q;
  assign gpio_bus.adr   = adr_q;
  assign gpio_bus.sel   = sel_q;
  assign gpio_bus.dat_w = dat_q;
  assign gpio_bus.rst_n = rst_n;
  assign ram_bus.stb    = stb_q && (slv_q == SLV_RAM);
  assign ram_bus.we     = we_q;
  assign ram_bus.adr    = adr_q;
  assign ram_bus.sel    = sel_q;
  assign ram_bus.dat_w  = dat_q;
  assign ram_bus.rst_n  = rst_n;

  assign slv_ack = (gpio_bus.ack && slv_q == SLV_GPIO) ||
                   (ram_bus.ack && slv_q == SLV_RAM);
  assign local_reply = inta_q || (slv_q == SLV_DEF);

  // Read data mux
  always_comb begin
    case (slv_q)
      SLV_GPIO: slv_dat = gpio_bus.dat_r;
      SLV_RAM:  slv_dat = ram_bus.dat_r;
      default:  slv_dat = `SB_DEF_DATA;
    endcase
  end

  assign reply = inta_q ? `SB_IRQ_VEC_BASE + sb_dat_t'(iid_i) : slv_dat;

  // Sequencer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= BUS_IDLE;
      stb_q <= 1'b0;
    end else begin
      case (state)
        BUS_IDLE: if (m_cyc_i && m_stb_i) begin
          state <= BUS_WAIT;
          stb_q <= !inta_i && (slv_sel_i != SLV_DEF);
        end
        BUS_WAIT: if (local_reply || slv_ack) begin
          state <= BUS_ACK;
          stb_q <= 1'b0;  // Dropped in the cycle after ack
        end
        default: state <= BUS_IDLE;
      endcase
    end
  end

  // Request and reply payload
  always_ff @(posedge clk) begin
    if (state == BUS_IDLE) begin
      inta_q <= inta_i;
      slv_q  <= slv_sel_i;
      we_q   <= m_we_i;
      adr_q  <= m_adr_i;
      sel_q  <= m_sel_i;
      dat_q  <= m_dat_i;
    end
    if (state == BUS_WAIT) begin
      m_dat_o <= reply;
    end
  end

  assign m_ack_o = (state == BUS_ACK);
  // Pending bit clears on the edge that captures the vector
  assign irq_ack_o = (state == BUS_WAIT) && inta_q;

endmodule

// ==== source/addr_decode.sv ====
`timescale 1ns/100ps
`include "sys_bus_config.svh"

module addr_decode import sys_bus_pkg::*; (
  input  logic       io_i,   // High for IO space
  input  sb_adr_t    adr_i,
  output slave_sel_e sel_o
);

  // GPIO window, two words from the base
  localparam sb_adr_t GPIO_BASE = `SB_GPIO_BASE;
  localparam sb_adr_t GPIO_MASK = ~sb_adr_t'(1);

  logic gpio_hit;

  assign gpio_hit = (adr_i & GPIO_MASK) == GPIO_BASE;

  // Memory space is all base RAM
  always_comb begin
    if (!io_i) begin
      sel_o = SLV_RAM;
    end else if (gpio_hit) begin
      sel_o = SLV_GPIO;
    end else begin
      sel_o = SLV_DEF;  // Answered by the controller
    end
  end

endmodule

// ==== source/sbus_if.sv ====
`timescale 1ns/100ps

// Internal slave bus between the controller and one slave
interface sbus_if import sys_bus_pkg::*; ();

  logic    stb;
  logic    we;
  sb_adr_t adr;
  sb_sel_t sel;
  sb_dat_t dat_w;
  sb_dat_t dat_r;
  logic    ack;  // Single-cycle pulse
  logic    rst_n;  // Internal reset after hold

  modport master (
    output stb, we, adr, sel, dat_w, rst_n,
    input  dat_r, ack
  );

  modport slave (
    input  stb, we, adr, sel, dat_w, rst_n,
    output dat_r, ack
  );

endinterface

// ==== source/sys_bus_pkg.sv ====
`include "sys_bus_config.svh"

package sys_bus_pkg;

  typedef logic [`SB_ADR_W-1:0] sb_adr_t;
  typedef logic [`SB_DAT_W-1:0] sb_dat_t;
  typedef logic [`SB_SEL_W-1:0] sb_sel_t;

  typedef logic [`IRQ_N-1:0] irq_vec_t;
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;  // Index of a request line

  // Result of the address decode
  typedef enum logic [1:0] {SLV_RAM, SLV_GPIO, SLV_DEF} slave_sel_e;

  // Transaction sequencer
  typedef enum logic [1:0] {BUS_IDLE, BUS_WAIT, BUS_ACK} bus_state_e;

endpackage

// ==== source/sys_bus_config.svh ====
`ifndef SYS_BUS_CONFIG_SVH
`define SYS_BUS_CONFIG_SVH

// Bus widths
`define SB_ADR_W 19  // Word address, byte address bits [19:1]
`define SB_DAT_W 16
`define SB_SEL_W 2

// IO window of the switch and LED block, byte 0xF100 to 0xF103
`define SB_GPIO_BASE 19'h0_7880

// Reply constants
`define SB_DEF_DATA 16'hFFFF  // Unmapped IO reads
`define SB_IRQ_VEC_BASE 16'h0008  // Vector is base plus iid

// Interrupts and pins
`define IRQ_N 8
`define IRQ_ID_W 3
`define SW_W 10
`define LED_W 14

`define RST_HOLD_CYCLES 32  // Cycles of reset after rst_lck rises

`endif
